/* source/bus_pkg.sv */
// Bus address and data widths, word and byte-enable types
// Byte-enable merge used by the register devices
`default_nettype none

package bus_pkg;

  localparam int BusAddrWidth = 32;
  localparam int BusDataWidth = 32;

  typedef logic [BusAddrWidth-1:0]   addr_t;
  typedef logic [BusDataWidth-1:0]   data_t;
  typedef logic [BusDataWidth/8-1:0] strb_t;  // One bit per byte lane

  // Replace only the enabled byte lanes of a word
  function automatic data_t apply_be(data_t old_word, data_t new_word, strb_t be);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < BusDataWidth / 8; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

/* source/soc_map_pkg.sv */
// Device selection enum and the fixed memory map
// Register offsets of the GPIO and timer blocks
`default_nettype none

package soc_map_pkg;
  import bus_pkg::*;

  typedef enum logic [1:0] {
    Ram,
    Gpio,
    Timer,
    None    // Unmapped address
  } dev_sel_e;

  localparam int NrDevices   = 3;
  localparam int RegOffWidth = 12;  // Register select bits inside a 4 KiB window

  localparam addr_t RamSize   = 32'h0001_0000;  // 64 KiB
  localparam addr_t RamBase   = 32'h0010_0000;
  localparam addr_t RamMask   = ~(RamSize - 1);

  localparam addr_t GpioSize  = 32'h0000_1000;  // 4 KiB
  localparam addr_t GpioBase  = 32'h8000_0000;
  localparam addr_t GpioMask  = ~(GpioSize - 1);

  localparam addr_t TimerSize = 32'h0000_1000;  // 4 KiB
  localparam addr_t TimerBase = 32'h8000_2000;
  localparam addr_t TimerMask = ~(TimerSize - 1);

  typedef logic [RegOffWidth-1:0] reg_off_t;

  localparam reg_off_t GpioOutOff    = 12'h000;
  localparam reg_off_t GpioInOff     = 12'h004;

  localparam reg_off_t MtimeLoOff    = 12'h000;
  localparam reg_off_t MtimeHiOff    = 12'h004;
  localparam reg_off_t MtimecmpLoOff = 12'h008;
  localparam reg_off_t MtimecmpHiOff = 12'h00C;

endpackage

`default_nettype wire

/* source/dev_bus_if.sv */
// Request/response bus between the decoder and one device
`timescale 1ns/1ps
`default_nettype none

interface dev_bus_if #(
  parameter int AddrWidth = 32,
  parameter int DataWidth = 32
);

  logic                   req;     // High for one cycle per access
  logic [AddrWidth-1:0]   addr;
  logic                   we;
  logic [DataWidth/8-1:0] be;
  logic [DataWidth-1:0]   wdata;
  logic                   rvalid;  // One-cycle response, also for writes
  logic [DataWidth-1:0]   rdata;
  logic                   err;

  modport host (output req, addr, we, be, wdata, input rvalid, rdata, err);

  modport device (input req, addr, we, be, wdata, output rvalid, rdata, err);

endinterface

`default_nettype wire

/* source/bus_decoder.sv */
// Data-bus decoder for a single host
// Address decode, request routing, response return, unmapped error
`timescale 1ns/1ps
`default_nettype none

module bus_decoder
  import bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic     clk_sys_i,
  input  logic     rst_sys_ni,

  input  logic     host_req_i,
  input  logic     host_we_i,
  input  addr_t    host_addr_i,
  input  strb_t    host_be_i,
  input  data_t    host_wdata_i,
  output logic     host_gnt_o,
  output logic     host_rvalid_o,
  output logic     host_err_o,
  output data_t    host_rdata_o,

  dev_bus_if.host  ram_o,
  dev_bus_if.host  gpio_o,
  dev_bus_if.host  timer_o
);

  localparam addr_t DevBase [NrDevices] = '{RamBase, GpioBase, TimerBase};
  localparam addr_t DevMask [NrDevices] = '{RamMask, GpioMask, TimerMask};

  dev_sel_e sel_d;
  dev_sel_e sel_q;         // Device of the access in flight
  logic     outstanding_q;
  logic     none_rsp_q;    // Error response for an unmapped access
  logic     accept;
  logic     dev_rvalid;
  data_t    dev_rdata;
  logic     dev_err;

  // Lowest index wins, windows do not overlap anyway
  always_comb begin
    sel_d = None;
    for (int i = NrDevices - 1; i >= 0; i--) begin
      if ((host_addr_i & DevMask[i]) == DevBase[i]) begin
        sel_d = dev_sel_e'(i);
      end
    end
  end

  assign host_gnt_o = ~outstanding_q;  // One access in flight at a time
  assign accept     = host_req_i & host_gnt_o;

  assign ram_o.req   = accept & (sel_d == Ram);
  assign gpio_o.req  = accept & (sel_d == Gpio);
  assign timer_o.req = accept & (sel_d == Timer);

  // Address and write data go to every device, req picks one
  assign ram_o.addr    = host_addr_i;
  assign ram_o.we      = host_we_i;
  assign ram_o.be      = host_be_i;
  assign ram_o.wdata   = host_wdata_i;
  assign gpio_o.addr   = host_addr_i;
  assign gpio_o.we     = host_we_i;
  assign gpio_o.be     = host_be_i;
  assign gpio_o.wdata  = host_wdata_i;
  assign timer_o.addr  = host_addr_i;
  assign timer_o.we    = host_we_i;
  assign timer_o.be    = host_be_i;
  assign timer_o.wdata = host_wdata_i;

  always_comb begin
    unique case (sel_q)
      Ram: begin
        dev_rvalid = ram_o.rvalid;
        dev_rdata  = ram_o.rdata;
        dev_err    = 1'b0;  // External RAM never errs
      end
      Gpio: begin
        dev_rvalid = gpio_o.rvalid;
        dev_rdata  = gpio_o.rdata;
        dev_err    = gpio_o.err;
      end
      Timer: begin
        dev_rvalid = timer_o.rvalid;
        dev_rdata  = timer_o.rdata;
        dev_err    = timer_o.err;
      end
      default: begin
        dev_rvalid = none_rsp_q;
        dev_rdata  = '0;
        dev_err    = none_rsp_q;
      end
    endcase
  end

  assign host_rvalid_o = outstanding_q & dev_rvalid;
  assign host_rdata_o  = dev_rdata;
  assign host_err_o    = dev_err;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      outstanding_q <= 1'b0;
      sel_q         <= None;
      none_rsp_q    <= 1'b0;
    end else begin
      none_rsp_q <= accept & (sel_d == None);
      if (accept) begin
        outstanding_q <= 1'b1;
        sel_q         <= sel_d;
      end else if (host_rvalid_o) begin
        outstanding_q <= 1'b0;  // Grant reopens after the response
      end
    end
  end

endmodule

`default_nettype wire

/* source/instr_fetch_port.sv */
// Instruction fetch path with a configurable delay
// RAM-window filter, grant and rvalid generation
`timescale 1ns/1ps
`default_nettype none

module instr_fetch_port
  import bus_pkg::*;
  import soc_map_pkg::*;
#(
  parameter int FetchDelay = 1
) (
  input  logic  clk_sys_i,
  input  logic  rst_sys_ni,

  input  logic  instr_req_i,
  input  addr_t instr_addr_i,
  output logic  instr_gnt_o,
  output logic  instr_rvalid_o,
  output data_t instr_rdata_o,

  output logic  mem_req_o,
  output addr_t mem_addr_o,
  input  data_t mem_rdata_i
);

  if (FetchDelay < 1) begin : g_bad_delay
    $error("FetchDelay must be at least 1");
  end

  logic [FetchDelay-1:0] req_q;
  addr_t                 addr_q [FetchDelay];
  logic                  req_dly;
  addr_t                 addr_dly;
  logic                  in_ram;
  logic                  rvalid_q;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      req_q    <= '0;
      rvalid_q <= 1'b0;
    end else begin
      req_q[0] <= instr_req_i;
      for (int i = 1; i < FetchDelay; i++) begin
        req_q[i] <= req_q[i-1];
      end
      rvalid_q <= instr_gnt_o;  // Memory answers one cycle after req
    end
  end

  always_ff @(posedge clk_sys_i) begin
    addr_q[0] <= instr_addr_i;
    for (int i = 1; i < FetchDelay; i++) begin
      addr_q[i] <= addr_q[i-1];
    end
  end

  assign req_dly  = req_q[FetchDelay-1];
  assign addr_dly = addr_q[FetchDelay-1];
  assign in_ram   = (addr_dly & RamMask) == RamBase;

  assign instr_gnt_o    = req_dly & in_ram;  // Fetches outside RAM wait forever
  assign mem_req_o      = instr_gnt_o;
  assign mem_addr_o     = addr_dly;
  assign instr_rvalid_o = rvalid_q;
  assign instr_rdata_o  = mem_rdata_i;

endmodule

`default_nettype wire

/* source/gpio_regs.sv */
// GPIO device with a byte-writable output register
// Two-flop synchronizer on the inputs
`timescale 1ns/1ps
`default_nettype none

module gpio_regs
  import bus_pkg::*;
  import soc_map_pkg::*;
#(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,

  dev_bus_if.device           bus_i,

  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o
);

  logic [GpoWidth-1:0] gpo_q;
  logic [GpiWidth-1:0] gpi_meta_q;
  logic [GpiWidth-1:0] gpi_sync_q;
  logic                rvalid_q;
  data_t               rdata_q;
  reg_off_t            off;
  data_t               gpo_next;

  assign off      = bus_i.addr[RegOffWidth-1:0];
  assign gpo_next = apply_be(data_t'(gpo_q), bus_i.wdata, bus_i.be);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q      <= '0;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
      rvalid_q   <= bus_i.req;
      if (bus_i.req && bus_i.we && off == GpioOutOff) begin
        gpo_q <= gpo_next[GpoWidth-1:0];  // Upper lanes drop off
      end
    end
  end

  // Only the input register reads back a value
  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req && !bus_i.we && off == GpioInOff) begin
      rdata_q <= data_t'(gpi_sync_q);
    end else begin
      rdata_q <= '0;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign bus_i.err    = 1'b0;
  assign gp_o         = gpo_q;

endmodule

`default_nettype wire

/* source/timer_regs.sv */
// Machine timer with 64-bit mtime and mtimecmp
// Registered interrupt when mtime reaches mtimecmp
`timescale 1ns/1ps
`default_nettype none

module timer_regs
  import bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,

  dev_bus_if.device bus_i,

  output logic      timer_irq_o
);

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        irq_q;
  logic        rvalid_q;
  logic        err_q;
  data_t       rdata_q;
  reg_off_t    off;
  logic        wr;
  logic        off_ok;
  data_t       rd_word;

  assign off = bus_i.addr[RegOffWidth-1:0];
  assign wr  = bus_i.req & bus_i.we;

  always_comb begin
    off_ok = 1'b1;
    case (off)
      MtimeLoOff:    rd_word = mtime_q[31:0];
      MtimeHiOff:    rd_word = mtime_q[63:32];
      MtimecmpLoOff: rd_word = mtimecmp_q[31:0];
      MtimecmpHiOff: rd_word = mtimecmp_q[63:32];
      default: begin
        rd_word = '0;
        off_ok  = 1'b0;  // Answered with err
      end
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;   // No interrupt until software sets a compare
      irq_q      <= 1'b0;
      rvalid_q   <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req;
      err_q    <= bus_i.req & ~off_ok;
      irq_q    <= mtime_q >= mtimecmp_q;
      if (wr && off == MtimeLoOff) begin
        mtime_q[31:0] <= apply_be(mtime_q[31:0], bus_i.wdata, bus_i.be);
      end else if (wr && off == MtimeHiOff) begin
        mtime_q[63:32] <= apply_be(mtime_q[63:32], bus_i.wdata, bus_i.be);
      end else begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr && off == MtimecmpLoOff) begin
        mtimecmp_q[31:0] <= apply_be(mtimecmp_q[31:0], bus_i.wdata, bus_i.be);
      end
      if (wr && off == MtimecmpHiOff) begin
        mtimecmp_q[63:32] <= apply_be(mtimecmp_q[63:32], bus_i.wdata, bus_i.be);
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    rdata_q <= (bus_i.req && !bus_i.we) ? rd_word : '0;  // Writes return zero
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign bus_i.err    = err_q;
  assign timer_irq_o  = irq_q;

endmodule

`default_nettype wire

/* source/demo_soc_fabric.sv */
// Top level of the system fabric around the core
// Data decoder, GPIO, timer, fetch path and external memory ports
`timescale 1ns/1ps
`default_nettype none

module demo_soc_fabric
  import bus_pkg::*;
#(
  parameter int GpiWidth   = 8,
  parameter int GpoWidth   = 16,
  parameter int FetchDelay = 1
) (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,

  // Data bus from the core
  input  logic                data_req_i,
  input  addr_t               data_addr_i,
  input  logic                data_we_i,
  input  strb_t               data_be_i,
  input  data_t               data_wdata_i,
  output logic                data_gnt_o,
  output logic                data_rvalid_o,
  output data_t               data_rdata_o,
  output logic                data_err_o,

  // Instruction bus from the core
  input  logic                instr_req_i,
  input  addr_t               instr_addr_i,
  output logic                instr_gnt_o,
  output logic                instr_rvalid_o,
  output data_t               instr_rdata_o,

  // External memory, port 0 data and port 1 fetch
  output logic                mem0_req_o,
  output logic                mem0_we_o,
  output strb_t               mem0_be_o,
  output addr_t               mem0_addr_o,
  output data_t               mem0_wdata_o,
  input  logic                mem0_rvalid_i,
  input  data_t               mem0_rdata_i,
  output logic                mem1_req_o,
  output addr_t               mem1_addr_o,
  input  data_t               mem1_rdata_i,

  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o,
  output logic                timer_irq_o
);

  dev_bus_if #(.AddrWidth(BusAddrWidth), .DataWidth(BusDataWidth)) ram_bus ();
  dev_bus_if #(.AddrWidth(BusAddrWidth), .DataWidth(BusDataWidth)) gpio_bus ();
  dev_bus_if #(.AddrWidth(BusAddrWidth), .DataWidth(BusDataWidth)) timer_bus ();

  bus_decoder u_bus_decoder (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .host_req_i    (data_req_i),
    .host_we_i     (data_we_i),
    .host_addr_i   (data_addr_i),
    .host_be_i     (data_be_i),
    .host_wdata_i  (data_wdata_i),
    .host_gnt_o    (data_gnt_o),
    .host_rvalid_o (data_rvalid_o),
    .host_err_o    (data_err_o),
    .host_rdata_o  (data_rdata_o),
    .ram_o         (ram_bus.host),
    .gpio_o        (gpio_bus.host),
    .timer_o       (timer_bus.host)
  );

  // RAM device is the external port 0
  assign mem0_req_o     = ram_bus.req;
  assign mem0_we_o      = ram_bus.we;
  assign mem0_be_o      = ram_bus.be;
  assign mem0_addr_o    = ram_bus.addr;
  assign mem0_wdata_o   = ram_bus.wdata;
  assign ram_bus.rvalid = mem0_rvalid_i;
  assign ram_bus.rdata  = mem0_rdata_i;

  gpio_regs #(
    .GpiWidth (GpiWidth),
    .GpoWidth (GpoWidth)
  ) u_gpio_regs (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .bus_i      (gpio_bus.device),
    .gp_i       (gp_i),
    .gp_o       (gp_o)
  );

  timer_regs u_timer_regs (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .bus_i       (timer_bus.device),
    .timer_irq_o (timer_irq_o)
  );

  instr_fetch_port #(
    .FetchDelay (FetchDelay)
  ) u_instr_fetch_port (
    .clk_sys_i      (clk_sys_i),
    .rst_sys_ni     (rst_sys_ni),
    .instr_req_i    (instr_req_i),
    .instr_addr_i   (instr_addr_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_rdata_o  (instr_rdata_o),
    .mem_req_o      (mem1_req_o),
    .mem_addr_o     (mem1_addr_o),
    .mem_rdata_i    (mem1_rdata_i)
  );

endmodule

`default_nettype wire

/* tests/demo_soc_fabric_asserts.sv */
// Bus timing assertions bound to the fabric top level
// Data response against grant, fetch grant to rvalid, port 1 request
`timescale 1ns/1ps
`default_nettype none

module demo_soc_fabric_asserts (
  input logic clk_sys_i,
  input logic rst_sys_ni,
  input logic data_gnt_i,
  input logic data_rvalid_i,
  input logic instr_gnt_i,
  input logic instr_rvalid_i,
  input logic mem1_req_i
);

  int unsigned fail_count = 0;  // Read by the testbench at the end

  // A response only comes back for an accepted access
  rvalid_while_granted: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni)
    $rose(data_rvalid_i) |-> !data_gnt_i
  ) else begin
    $error("data_rvalid_o rose while data_gnt_o was high");
    fail_count++;
  end

  fetch_rvalid_after_gnt: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni)
    instr_gnt_i |=> instr_rvalid_i
  ) else begin
    $error("instr_rvalid_o missing one cycle after instr_gnt_o");
    fail_count++;
  end

  // No rvalid without a grant in the cycle before
  fetch_rvalid_has_gnt: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni)
    instr_rvalid_i |-> $past(instr_gnt_i)
  ) else begin
    $error("instr_rvalid_o without instr_gnt_o one cycle before");
    fail_count++;
  end

  mem1_req_is_gnt: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni)
    mem1_req_i == instr_gnt_i
  ) else begin
    $error("mem1_req_o differs from instr_gnt_o");
    fail_count++;
  end

endmodule

`default_nettype wire

/* tests/tb_demo_soc_fabric.sv */
// System fabric testbench with clock, reset and memory models
// Case file reader, compare tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_demo_soc_fabric
  import bus_pkg::*;
();

  localparam int    GpiWidth    = 8;
  localparam int    GpoWidth    = 16;
  localparam int    FetchDelay  = 1;
  localparam int    ResetCycles = 16;
  localparam int    MemWords    = 16384;         // 64 KiB of words
  localparam addr_t RamLo       = 32'h0010_0000;
  localparam addr_t RamHi       = 32'h0010_FFFF;

  logic                clk_sys_i;
  logic                rst_sys_ni;
  logic                data_req_i;
  addr_t               data_addr_i;
  logic                data_we_i;
  strb_t               data_be_i;
  data_t               data_wdata_i;
  logic                data_gnt_o;
  logic                data_rvalid_o;
  data_t               data_rdata_o;
  logic                data_err_o;
  logic                instr_req_i;
  addr_t               instr_addr_i;
  logic                instr_gnt_o;
  logic                instr_rvalid_o;
  data_t               instr_rdata_o;
  logic                mem0_req_o;
  logic                mem0_we_o;
  strb_t               mem0_be_o;
  addr_t               mem0_addr_o;
  data_t               mem0_wdata_o;
  logic                mem0_rvalid_i;
  data_t               mem0_rdata_i;
  logic                mem1_req_o;
  addr_t               mem1_addr_o;
  data_t               mem1_rdata_i;
  logic [GpiWidth-1:0] gp_i;
  logic [GpoWidth-1:0] gp_o;
  logic                timer_irq_o;

  data_t       mem0 [MemWords];
  data_t       mem1 [MemWords];
  logic [15:0] kind_q [$];  // Two-letter case kind
  addr_t       addr_q [$];
  data_t       data_q [$];
  strb_t       be_q [$];
  logic        err_q [$];
  data_t       exp_q [$];

  int    seed         = 51;
  int    value_errs   = 0;
  int    other_errs   = 0;
  bit    cases_loaded = 1'b0;
  int    m0_count     = 0;     // mem0_req_o pulses seen
  logic  m0_pend      = 1'b0;
  logic  m0_we;
  addr_t m0_addr;
  strb_t m0_be;
  data_t m0_wdata;
  addr_t m1_addr      = '0;
  data_t mtime_prev   = '0;

  demo_soc_fabric #(
    .GpiWidth   (GpiWidth),
    .GpoWidth   (GpoWidth),
    .FetchDelay (FetchDelay)
  ) UUT (.*);

  bind demo_soc_fabric demo_soc_fabric_asserts u_asserts (
    .clk_sys_i      (clk_sys_i),
    .rst_sys_ni     (rst_sys_ni),
    .data_gnt_i     (data_gnt_o),
    .data_rvalid_i  (data_rvalid_o),
    .instr_gnt_i    (instr_gnt_o),
    .instr_rvalid_i (instr_rvalid_o),
    .mem1_req_i     (mem1_req_o)
  );

  initial begin
    clk_sys_i = 1'b0;
    forever #4 clk_sys_i = ~clk_sys_i;
  end

  function automatic int widx(addr_t a);
    return int'(a[15:2]);
  endfunction

  function automatic logic in_ram(addr_t a);
    return (a >= RamLo) && (a <= RamHi);
  endfunction

  // Memory models capture requests on the rising edge
  always @(posedge clk_sys_i) begin
    m0_pend <= mem0_req_o;
    if (mem0_req_o) begin
      m0_count <= m0_count + 1;
      m0_we    <= mem0_we_o;
      m0_addr  <= mem0_addr_o;
      m0_be    <= mem0_be_o;
      m0_wdata <= mem0_wdata_o;
      for (int b = 0; b < 4; b++) begin
        if (mem0_we_o && mem0_be_o[b]) begin
          mem0[widx(mem0_addr_o)][8*b +: 8] <= mem0_wdata_o[8*b +: 8];
        end
      end
    end
    if (mem1_req_o) begin
      m1_addr <= mem1_addr_o;
    end
  end

  // Responses go out on the falling edge one cycle after the request
  always @(negedge clk_sys_i) begin
    mem0_rvalid_i <= m0_pend;
    mem0_rdata_i  <= (m0_pend && !m0_we) ? mem0[widx(m0_addr)] : '0;
    mem1_rdata_i  <= mem1[widx(m1_addr)];
  end

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    logic [15:0] kind;
    addr_t       a;
    data_t       d;
    data_t       e;
    strb_t       b;
    logic        er;
    fd = $fopen("tests/fabric_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file tests/fabric_cases.txt");
      other_errs++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %h %h %h %h %h", kind, a, d, b, er, e);
        if (n == 6) begin
          kind_q.push_back(kind);
          addr_q.push_back(a);
          data_q.push_back(d);
          be_q.push_back(b);
          err_q.push_back(er);
          exp_q.push_back(e);
        end else if (n > 0) begin
          $display("Malformed line in the case file: %s", line);
          other_errs++;
        end
      end
    end
    $fclose(fd);
  endtask

  // One data-bus access held until granted
  task automatic data_access(input logic we, input addr_t addr, input data_t wdata,
                             input strb_t be, output data_t rdata, output logic err);
    int waited;
    waited = 0;
    @(negedge clk_sys_i);
    data_req_i   = 1'b1;
    data_we_i    = we;
    data_addr_i  = addr;
    data_be_i    = be;
    data_wdata_i = wdata;
    @(posedge clk_sys_i);
    while (!data_gnt_o && waited < 32) begin
      waited++;
      @(posedge clk_sys_i);
    end
    check_flag("data_gnt_o", 1'b1, data_gnt_o);
    @(negedge clk_sys_i);
    data_req_i = 1'b0;
    do begin
      @(posedge clk_sys_i);
      waited++;
    end while (!data_rvalid_o && waited < 64);
    if (!data_rvalid_o) begin
      $display("Data access to 0x%h got no response", addr);
      other_errs++;
    end
    check_flag("data_gnt_o", 1'b0, data_gnt_o);  // Closed until the response
    rdata = data_rdata_o;
    err   = data_err_o;
  endtask

  task automatic fetch(input addr_t addr, input logic gnt_exp);
    logic  seen;
    data_t word;
    seen = 1'b0;
    @(negedge clk_sys_i);
    instr_req_i  = 1'b1;
    instr_addr_i = addr;
    @(posedge clk_sys_i);  // Request enters the delay stages
    if (gnt_exp) begin
      @(negedge clk_sys_i);
      instr_req_i = 1'b0;
      repeat (FetchDelay) @(posedge clk_sys_i);
      check_flag("instr_gnt_o", 1'b1, instr_gnt_o);
      check_addr("mem1_addr_o", addr, mem1_addr_o);
      word = mem1[widx(addr)];
      @(posedge clk_sys_i);
      check_flag("instr_rvalid_o", 1'b1, instr_rvalid_o);
      check_data("instr_rdata_o", word, instr_rdata_o);
    end else begin
      repeat (FetchDelay + 4) begin
        @(posedge clk_sys_i);
        seen = seen | instr_gnt_o;
      end
      check_flag("instr_gnt_o", 1'b0, seen);
      @(negedge clk_sys_i);
      instr_req_i = 1'b0;
    end
    repeat (FetchDelay + 1) @(posedge clk_sys_i);  // Drain the delay stages
  endtask

  task automatic run_case(input int i);
    data_t rdata;
    data_t word;
    logic  err;
    int    m0_before;
    m0_before = m0_count;
    case (kind_q[i])
      "wr", "rd": begin
        data_access(kind_q[i] == "wr", addr_q[i], data_q[i], be_q[i], rdata, err);
        check_flag("data_err_o", err_q[i], err);
        check_data("data_rdata_o", exp_q[i], rdata);
        check_flag("mem0_req_o", in_ram(addr_q[i]), m0_count != m0_before);
        if (kind_q[i] == "wr" && in_ram(addr_q[i])) begin
          check_addr("mem0_addr_o", addr_q[i], m0_addr);
          check_flag("mem0_we_o", 1'b1, m0_we);
          check_data("mem0_be_o", data_t'(be_q[i]), data_t'(m0_be));
          check_data("mem0_wdata_o", data_q[i], m0_wdata);
        end
      end
      "rm": begin
        word = mem0[widx(addr_q[i])];
        data_access(1'b0, addr_q[i], '0, be_q[i], rdata, err);
        check_flag("data_err_o", 1'b0, err);
        check_data("data_rdata_o", word, rdata);
      end
      "mt": begin
        data_access(1'b0, addr_q[i], '0, be_q[i], rdata, err);
        check_flag("data_err_o", 1'b0, err);
        check_flag("mtime_lo_increasing", 1'b1, rdata > mtime_prev);
        mtime_prev = rdata;
      end
      "iq": begin
        repeat (2) @(posedge clk_sys_i);
        check_flag("timer_irq_o", exp_q[i][0], timer_irq_o);
      end
      "gi": begin
        @(negedge clk_sys_i);
        gp_i = GpiWidth'($random(seed));
        repeat (3) @(posedge clk_sys_i);  // Through the synchronizer
        data_access(1'b0, addr_q[i], '0, be_q[i], rdata, err);
        check_flag("data_err_o", 1'b0, err);
        check_data("data_rdata_o", data_t'(gp_i), rdata);
      end
      "go": begin
        @(posedge clk_sys_i);
        check_data("gp_o", exp_q[i], data_t'(gp_o));
      end
      "fe": fetch(addr_q[i], exp_q[i][0]);
      default: begin
        $display("Case %0d has an unknown kind", i);
        other_errs++;
      end
    endcase
  endtask

  // Watchdog sized from the number of cases
  initial begin
    wait (cases_loaded);
    repeat (ResetCycles + 4 + 64 * kind_q.size()) @(posedge clk_sys_i);
    other_errs++;
    $display("Timeout: the run did not finish in the expected number of cycles");
    $display("Summary: %0d check mismatches, %0d other failures, %0d assertion failures",
             value_errs, other_errs, UUT.u_asserts.fail_count);
    $display("Errors found");
    $finish;
  end

  initial begin
    rst_sys_ni    = 1'b0;
    data_req_i    = 1'b0;
    data_addr_i   = '0;
    data_we_i     = 1'b0;
    data_be_i     = '0;
    data_wdata_i  = '0;
    instr_req_i   = 1'b0;
    instr_addr_i  = '0;
    mem0_rvalid_i = 1'b0;
    mem0_rdata_i  = '0;
    mem1_rdata_i  = '0;
    gp_i          = '0;
    for (int w = 0; w < MemWords; w++) begin
      mem0[w] = $random(seed);
      mem1[w] = $random(seed);
    end
    load_cases();
    cases_loaded = 1'b1;
    repeat (ResetCycles) @(negedge clk_sys_i);
    rst_sys_ni = 1'b1;
    for (int i = 0; i < kind_q.size(); i++) begin
      run_case(i);
    end
    repeat (4) @(posedge clk_sys_i);
    other_errs += UUT.u_asserts.fail_count;
    $display("Summary: %0d check mismatches, %0d other failures, %0d assertion failures",
             value_errs, other_errs, UUT.u_asserts.fail_count);
    if (value_errs + other_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/fabric_cases.txt */
# kind addr data be err expect, all hex
# wr/rd data write/read, rm RAM read against model, mt mtime read, iq irq level
# gi set gp_i and read it, go gp_o value, fe fetch (expect 1 when granted)
wr 00100040 cafef00d f 0 0
rd 00100040 0 f 0 cafef00d
wr 00100044 11223344 5 0 0
rm 00100044 0 f 0 0
rm 00100100 0 f 0 0
wr 0010fffc 0badbeef f 0 0
rd 0010fffc 0 f 0 0badbeef
wr 80000000 a5a51234 f 0 0
go 0 0 0 0 1234
wr 80000000 ffffbeef 2 0 0
go 0 0 0 0 be34
rd 80000000 0 f 0 0
gi 80000004 0 f 0 0
gi 80000004 0 f 0 0
rd 00200000 0 f 1 0
wr 40000000 12345678 f 1 0
rd 80001000 0 f 1 0
rd 00110000 0 f 1 0
mt 80002000 0 f 0 0
mt 80002000 0 f 0 0
iq 0 0 0 0 0
wr 80002008 00000010 f 0 0
wr 8000200c 00000000 f 0 0
iq 0 0 0 0 1
wr 8000200c ffffffff f 0 0
wr 80002008 ffffffff f 0 0
iq 0 0 0 0 0
rd 80002010 0 f 1 0
fe 00100000 0 0 0 1
fe 0010fff8 0 0 0 1
fe 80000000 0 0 0 0

/* sources.f */
source/bus_pkg.sv
source/soc_map_pkg.sv
source/dev_bus_if.sv
source/bus_decoder.sv
source/instr_fetch_port.sv
source/gpio_regs.sv
source/timer_regs.sv
source/demo_soc_fabric.sv
tests/demo_soc_fabric_asserts.sv
tests/tb_demo_soc_fabric.sv
